// File: build.f
+incdir+.
rename_pkg.sv
register_map.sv
rob_pointers.sv
rob_entries.sv
retire_control.sv
rename_unit.sv
rename_assert.sv
rename_unit_tb.sv

// File: Bender.yml
package:
  name: rename_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rename_pkg.sv
      - register_map.sv
      - rob_pointers.sv
      - rob_entries.sv
      - retire_control.sv
      - rename_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - rename_assert.sv
      - rename_unit_tb.sv

// File: rename_unit_tb.sv
// Directed testbench for the rename unit: reference model, clock, reset, timeout and test tasks

`timescale 1ns/100ps

`include "rename_config.svh"

module rename_unit_tb;

    localparam int RW = $clog2(`ADDR_WIDTH);

    logic                   clk;
    logic                   n_rst;
    logic                   i_dispatch_valid;
    logic [RW-1:0]          i_dispatch_rdest;
    logic [RW-1:0]          i_dispatch_rsrc [0:1];
    logic                   o_dispatch_ready;
    logic [`TAG_WIDTH-1:0]  o_dispatch_tag;
    logic                   o_src_rdy  [0:1];
    logic [`TAG_WIDTH-1:0]  o_src_tag  [0:1];
    logic [`DATA_WIDTH-1:0] o_src_data [0:1];
    logic                   i_wb_valid;
    logic [`TAG_WIDTH-1:0]  i_wb_tag;
    logic [`DATA_WIDTH-1:0] i_wb_data;
    logic                   i_flush;
    logic                   o_retire_valid;
    logic [RW-1:0]          o_retire_rdest;
    logic [`TAG_WIDTH-1:0]  o_retire_tag;
    logic [`DATA_WIDTH-1:0] o_retire_data;

    // Reference model of the architectural state and the in-flight entries
    logic [`DATA_WIDTH-1:0] arch_val   [`ADDR_WIDTH];
    logic                   arch_known [`ADDR_WIDTH];
    logic [`TAG_WIDTH-1:0]  map_tag    [`ADDR_WIDTH];
    logic                   map_rdy    [`ADDR_WIDTH];
    logic [RW-1:0]          ent_rdest  [`ROB_DEPTH];
    logic                   ent_done   [`ROB_DEPTH];
    logic [`DATA_WIDTH-1:0] ent_data   [`ROB_DEPTH];
    logic [`TAG_WIDTH-1:0]  flight_q   [$];
    logic [`TAG_WIDTH-1:0]  tail_m;
    logic                   flush_m;
    integer                 errors;
    integer                 checks;
    integer                 cycles;
    integer                 seed;

    rename_unit dut_i (.*);

    always #5 clk = ~clk;

    // The tests need well under a hundred cycles, so this limit only trips on a hang
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= 2000) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic compare(input string what, input logic [`DATA_WIDTH-1:0] got,
                           input logic [`DATA_WIDTH-1:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Registers r1 to r15, r0 is left to the reset test
    function automatic logic [RW-1:0] random_reg();
        return RW'(($unsigned($random(seed)) % (`ADDR_WIDTH - 1)) + 1);
    endfunction

    // Drive both lookups and compare against the state before this cycle's rename
    task automatic check_sources(input logic [RW-1:0] ra, input logic [RW-1:0] rb);
        logic [RW-1:0] r;
        i_dispatch_rsrc[0] = ra;
        i_dispatch_rsrc[1] = rb;
        #1;
        for (int s = 0; s < 2; s++) begin
            r = (s == 0) ? ra : rb;
            if (map_rdy[r]) begin
                compare("o_src_rdy", o_src_rdy[s], 1'b1);
                if (arch_known[r]) compare("o_src_data", o_src_data[s], arch_val[r]);
            end else begin
                // Not ready in the map, so the answer comes from the producing entry
                compare("o_src_rdy", o_src_rdy[s], ent_done[map_tag[r]]);
                compare("o_src_tag", o_src_tag[s], map_tag[r]);
                if (ent_done[map_tag[r]]) begin
                    compare("o_src_data", o_src_data[s], ent_data[map_tag[r]]);
                end
            end
        end
    endtask

    // One clock cycle: check status and retirement, then update the model at the edge
    task automatic advance();
        logic [`TAG_WIDTH-1:0] h;
        logic                  retire_exp;
        logic                  ready_exp;
        #1;
        retire_exp = 1'b0;
        if (!flush_m && flight_q.size() > 0) retire_exp = ent_done[flight_q[0]];
        ready_exp = !flush_m && (flight_q.size() < `ROB_DEPTH);
        compare("o_dispatch_ready", o_dispatch_ready, ready_exp);
        compare("o_retire_valid", o_retire_valid, retire_exp);
        if (retire_exp && o_retire_valid) begin
            compare("o_retire_tag", o_retire_tag, flight_q[0]);
            compare("o_retire_rdest", o_retire_rdest, ent_rdest[flight_q[0]]);
            compare("o_retire_data", o_retire_data, ent_data[flight_q[0]]);
        end
        @(posedge clk);
        if (retire_exp) begin
            h = flight_q.pop_front();
            ent_done[h] = 1'b0;
            if (ent_rdest[h] != 0) begin
                arch_val[ent_rdest[h]]   = ent_data[h];
                arch_known[ent_rdest[h]] = 1'b1;
                // Only the latest producer makes the register ready
                if (map_tag[ent_rdest[h]] == h) map_rdy[ent_rdest[h]] = 1'b1;
            end
        end
        // Rename is applied after retire, so it wins on the same register
        if (i_dispatch_valid && ready_exp) begin
            ent_rdest[tail_m] = i_dispatch_rdest;
            ent_done[tail_m]  = 1'b0;
            if (i_dispatch_rdest != 0) begin
                map_rdy[i_dispatch_rdest] = 1'b0;
                map_tag[i_dispatch_rdest] = tail_m;
            end
            flight_q.push_back(tail_m);
            tail_m = tail_m + 1'b1;
        end
        if (i_wb_valid) begin
            ent_done[i_wb_tag] = 1'b1;
            ent_data[i_wb_tag] = i_wb_data;
        end
        // The edge that ends the FLUSH cycle empties the buffer
        if (flush_m) begin
            flight_q.delete();
            for (int i = 0; i < `ADDR_WIDTH; i++) map_rdy[i] = 1'b1;
            for (int i = 0; i < `ROB_DEPTH; i++) ent_done[i] = 1'b0;
            tail_m  = '0;
            flush_m = 1'b0;
        end
        if (i_flush) flush_m = 1'b1;
        @(negedge clk);
        i_dispatch_valid = 1'b0;
        i_wb_valid       = 1'b0;
        i_flush          = 1'b0;
    endtask

    task automatic dispatch(input logic [RW-1:0] rd, input logic [RW-1:0] rs0,
                            input logic [RW-1:0] rs1);
        if (!o_dispatch_ready) begin
            errors = errors + 1;
            $display("Dispatch at %0d ns was refused while the buffer had room", $time);
        end else begin
            i_dispatch_valid = 1'b1;
            i_dispatch_rdest = rd;
            check_sources(rs0, rs1);
            compare("o_dispatch_tag", o_dispatch_tag, tail_m);
            advance();
        end
    endtask

    task automatic writeback(input logic [`TAG_WIDTH-1:0] tag);
        i_wb_valid = 1'b1;
        i_wb_tag   = tag;
        i_wb_data  = $random(seed);
        advance();
    endtask

    // Let every completed entry retire, with a bound on the wait
    task automatic drain();
        integer n;
        n = 0;
        while (flight_q.size() > 0 && n < 20) begin
            advance();
            n = n + 1;
        end
        if (flight_q.size() > 0) begin
            errors = errors + 1;
            $display("Completed entries did not retire at %0d ns", $time);
        end
    endtask

    task automatic check_all_regs();
        for (int r = 0; r < `ADDR_WIDTH; r += 2) begin
            check_sources(RW'(r), RW'(r + 1));
            advance();
        end
    endtask

    // Ready after reset, r0 reads zero through the model's known value
    task automatic reset_values();
        check_all_regs();
    endtask

    // Source equal to the destination sees the older, ready value
    task automatic rename_dest(output logic [RW-1:0] rd);
        rd = random_reg();
        dispatch(rd, rd, '0);
        check_sources(rd, '0);
        advance();
    endtask

    // Younger entry completes while the head waits, so its value is forwarded
    task automatic forward_result(input logic [RW-1:0] rd);
        logic [RW-1:0] rd2;
        rd2 = RW'((rd % (`ADDR_WIDTH - 1)) + 1);
        dispatch(rd2, rd, rd2);
        writeback(flight_q[flight_q.size() - 1]);
        check_sources(rd2, rd);
        advance();
    endtask

    task automatic retire_in_order();
        logic [`TAG_WIDTH-1:0] tags [$];
        for (int i = 0; i < 3; i++) dispatch(random_reg(), random_reg(), random_reg());
        tags = flight_q;
        // Reverse order, so the head completes last
        for (int i = tags.size() - 1; i >= 0; i--) begin
            if (!ent_done[tags[i]]) writeback(tags[i]);
        end
        drain();
        check_all_regs();
    endtask

    task automatic double_rename();
        logic [RW-1:0] rd;
        rd = random_reg();
        dispatch(rd, '0, '0);
        dispatch(rd, rd, '0);
        writeback(flight_q[0]);
        advance();
        check_sources(rd, rd);
        advance();
        writeback(flight_q[0]);
        drain();
        check_sources(rd, '0);
        advance();
    endtask

    task automatic fill_then_flush();
        for (int i = 0; i < `ROB_DEPTH; i++) dispatch(random_reg(), random_reg(), random_reg());
        advance();
        writeback(flight_q[0]);
        // Head retires in the cycle that raises the flush
        i_flush = 1'b1;
        advance();
        advance();
        check_all_regs();
        dispatch(random_reg(), '0, '0);
        writeback(flight_q[0]);
        drain();
    endtask

    initial begin
        logic [RW-1:0] rd;
        clk                = 1'b0;
        n_rst              = 1'b0;
        i_dispatch_valid   = 1'b0;
        i_dispatch_rdest   = '0;
        i_dispatch_rsrc[0] = '0;
        i_dispatch_rsrc[1] = '0;
        i_wb_valid         = 1'b0;
        i_wb_tag           = '0;
        i_wb_data          = '0;
        i_flush            = 1'b0;
        errors             = 0;
        checks             = 0;
        cycles             = 0;
        seed               = 43647;
        tail_m             = '0;
        flush_m            = 1'b0;
        for (int i = 0; i < `ADDR_WIDTH; i++) begin
            arch_val[i]   = '0;
            arch_known[i] = (i == 0);
            map_tag[i]    = '0;
            map_rdy[i]    = 1'b1;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            ent_rdest[i] = '0;
            ent_done[i]  = 1'b0;
            ent_data[i]  = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        reset_values();
        rename_dest(rd);
        forward_result(rd);
        retire_in_order();
        double_rename();
        fill_then_flush();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.assert_i.failures);
        if (errors == 0 && dut_i.assert_i.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rename_assert.sv
// Concurrent assertions on reorder buffer occupancy, retirement and flush sequencing, with bind

`timescale 1ns/100ps

`include "rename_config.svh"

module rename_assert (
    input logic                clk,
    input logic                n_rst,
    input logic [`TAG_WIDTH:0] i_count,
    input logic                i_flush,
    input logic                i_dispatch_valid,
    input logic                i_dispatch_ready,
    input logic                i_retire_valid
);

    // Count of failed assertions
    int failures = 0;

    // Occupancy stays within the buffer
    a_count_bound: assert property (@(posedge clk) disable iff (!n_rst)
        i_count <= (`TAG_WIDTH+1)'(`ROB_DEPTH))
        else begin
            failures = failures + 1;
            $error("Reorder buffer count is above its depth");
        end

    // The cycle after a flush request is the FLUSH cycle
    // Nothing retires and no dispatch is accepted while the buffer is cleared
    a_no_retire_in_flush: assert property (@(posedge clk) disable iff (!n_rst)
        i_flush |=> (!i_retire_valid && !i_dispatch_ready))
        else begin
            failures = failures + 1;
            $error("Retirement or dispatch open during the flush cycle");
        end

    // Dispatch is only legal while the unit is ready
    a_dispatch_legal: assert property (@(posedge clk) disable iff (!n_rst)
        i_dispatch_valid |-> i_dispatch_ready)
        else begin
            failures = failures + 1;
            $error("Dispatch while not ready");
        end

endmodule

bind rename_unit rename_assert assert_i (
    .clk              (clk),
    .n_rst            (n_rst),
    .i_count          (count),
    .i_flush          (i_flush),
    .i_dispatch_valid (i_dispatch_valid),
    .i_dispatch_ready (o_dispatch_ready),
    .i_retire_valid   (o_retire_valid)
);

// File: rename_unit.sv
// Top level of the rename and retirement slice: register map, reorder buffer and retire FSM

`timescale 1ns/100ps

`include "rename_config.svh"

module rename_unit import rename_pkg::*; (
    input  logic                            clk,
    input  logic                            n_rst,

    // Dispatch of one instruction per cycle
    input  logic                            i_dispatch_valid,
    input  logic [$clog2(`ADDR_WIDTH)-1:0]  i_dispatch_rdest,
    input  logic [$clog2(`ADDR_WIDTH)-1:0]  i_dispatch_rsrc [0:1],
    output logic                            o_dispatch_ready,
    output logic [`TAG_WIDTH-1:0]           o_dispatch_tag,

    // Source operand status for the dispatched instruction
    output logic                            o_src_rdy  [0:1],
    output logic [`TAG_WIDTH-1:0]           o_src_tag  [0:1],
    output logic [`DATA_WIDTH-1:0]          o_src_data [0:1],

    // Execution result writeback
    input  logic                            i_wb_valid,
    input  logic [`TAG_WIDTH-1:0]           i_wb_tag,
    input  logic [`DATA_WIDTH-1:0]          i_wb_data,

    input  logic                            i_flush,

    // Retirement, one entry per cycle at most
    output logic                            o_retire_valid,
    output logic [$clog2(`ADDR_WIDTH)-1:0]  o_retire_rdest,
    output logic [`TAG_WIDTH-1:0]           o_retire_tag,
    output logic [`DATA_WIDTH-1:0]          o_retire_data
);

    logic [`TAG_WIDTH-1:0]  head;
    logic [`TAG_WIDTH-1:0]  tail;
    logic [`TAG_WIDTH:0]    count;
    logic                   full;
    logic                   empty;
    logic                   accept;
    logic                   retire;
    logic                   clear;
    rob_entry_t             head_entry;

    logic                   map_rdy  [0:1];
    logic [`TAG_WIDTH-1:0]  map_tag  [0:1];
    logic [`DATA_WIDTH-1:0] map_data [0:1];
    logic                   fwd_done [0:1];
    logic [`DATA_WIDTH-1:0] fwd_data [0:1];

    retire_control ctrl_i (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_dispatch_valid (i_dispatch_valid),
        .i_full           (full),
        .i_empty          (empty),
        .i_head_done      (head_entry.done),
        .o_dispatch_ready (o_dispatch_ready),
        .o_accept         (accept),
        .o_retire         (retire),
        .o_clear          (clear)
    );

    rob_pointers ptr_i (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_push  (accept),
        .i_pop   (retire),
        .i_clear (clear),
        .o_head  (head),
        .o_tail  (tail),
        .o_count (count),
        .o_full  (full),
        .o_empty (empty)
    );

    // Forwarding lookups use the tags that the register map holds for each source
    rob_entries rob_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_alloc       (accept),
        .i_alloc_tag   (tail),
        .i_alloc_rdest (i_dispatch_rdest),
        .i_wb_valid    (i_wb_valid),
        .i_wb_tag      (i_wb_tag),
        .i_wb_data     (i_wb_data),
        .i_release     (retire),
        .i_release_tag (head),
        .i_clear       (clear),
        .i_lookup_tag  (map_tag),
        .o_head_entry  (head_entry),
        .o_lookup_done (fwd_done),
        .o_lookup_data (fwd_data)
    );

    register_map map_i (
        .clk                   (clk),
        .n_rst                 (n_rst),
        .i_flush               (clear),
        .i_regmap_retire_data  (head_entry.data),
        .i_regmap_retire_rdest (head_entry.rdest),
        .i_regmap_retire_tag   (head),
        .i_regmap_retire_wr_en (retire),
        .i_regmap_rename_tag   (tail),
        .i_regmap_rename_rdest (i_dispatch_rdest),
        .i_regmap_rename_wr_en (accept),
        .i_regmap_lookup_rsrc  (i_dispatch_rsrc),
        .o_regmap_lookup_rdy   (map_rdy),
        .o_regmap_lookup_tag   (map_tag),
        .o_regmap_lookup_data  (map_data)
    );

    // A source is ready from the map or from a completed entry still in flight
    for (genvar s = 0; s < 2; s++) begin : g_src
        assign o_src_rdy[s]  = map_rdy[s] || fwd_done[s];
        assign o_src_tag[s]  = map_tag[s];
        assign o_src_data[s] = map_rdy[s] ? map_data[s] : fwd_data[s];
    end

    // The new instruction takes the tail slot as its tag
    assign o_dispatch_tag = tail;

    assign o_retire_valid = retire;
    assign o_retire_rdest = head_entry.rdest;
    assign o_retire_tag   = head;
    assign o_retire_data  = head_entry.data;

endmodule

// File: retire_control.sv
// Retire FSM: in-order retirement, dispatch acceptance and one-cycle flush sequencing

`timescale 1ns/100ps

`include "rename_config.svh"

module retire_control import rename_pkg::*; (
    input  logic clk,
    input  logic n_rst,

    input  logic i_flush,
    input  logic i_dispatch_valid,

    // Status of the reorder buffer
    input  logic i_full,
    input  logic i_empty,
    input  logic i_head_done,

    output logic o_dispatch_ready,
    output logic o_accept,
    output logic o_retire,
    output logic o_clear
);

    retire_state_t state_q;
    retire_state_t state_d;

    // Any flush request sends the FSM into one cycle of clearing
    always_comb begin
        state_d = RUN;
        if (i_flush) begin
            state_d = FLUSH;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // No new entries while the buffer is full or being cleared
    assign o_dispatch_ready = (state_q == RUN) && !i_full;
    assign o_accept         = o_dispatch_ready && i_dispatch_valid;

    // Oldest entry leaves once its result is in
    // A retirement in the cycle that raises i_flush still completes
    assign o_retire         = (state_q == RUN) && !i_empty && i_head_done;

    // Pointers, done bits and ready bits all clear at the edge that ends FLUSH
    assign o_clear          = (state_q == FLUSH);

endmodule

// File: rob_entries.sv
// Reorder buffer entry storage: allocate, writeback by tag, head read and operand forwarding

`timescale 1ns/100ps

`include "rename_config.svh"

module rob_entries import rename_pkg::*; (
    input  logic                            clk,
    input  logic                            n_rst,

    // Allocation at the tail for a dispatched instruction
    input  logic                            i_alloc,
    input  logic [`TAG_WIDTH-1:0]           i_alloc_tag,
    input  logic [$clog2(`ADDR_WIDTH)-1:0]  i_alloc_rdest,

    // Result from an execution unit, addressed by tag
    input  logic                            i_wb_valid,
    input  logic [`TAG_WIDTH-1:0]           i_wb_tag,
    input  logic [`DATA_WIDTH-1:0]          i_wb_data,

    // Retirement of the head entry, the release tag is also the head pointer
    input  logic                            i_release,
    input  logic [`TAG_WIDTH-1:0]           i_release_tag,

    // Flush clears every done bit
    input  logic                            i_clear,

    // Forwarding lookups for the tags that the register map returns
    input  logic [`TAG_WIDTH-1:0]           i_lookup_tag  [0:1],

    output rob_entry_t                      o_head_entry,
    output logic                            o_lookup_done [0:1],
    output logic [`DATA_WIDTH-1:0]          o_lookup_data [0:1]
);

    rob_entry_t entries_q [`ROB_DEPTH];

    // The head entry feeds retirement directly
    assign o_head_entry = entries_q[i_release_tag];

    // Completed but unretired results are visible here before they reach the register map
    for (genvar s = 0; s < 2; s++) begin : g_fwd
        assign o_lookup_done[s] = entries_q[i_lookup_tag[s]].done;
        assign o_lookup_data[s] = entries_q[i_lookup_tag[s]].data;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries_q[i] <= '0;
            end
        end else if (i_clear) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries_q[i].done <= 1'b0;
            end
        end else begin
            // Later statements win, so allocation overrides a stale writeback
            // to the same slot and a writeback to a free slot is harmless
            if (i_release) begin
                entries_q[i_release_tag].done <= 1'b0;
            end
            if (i_wb_valid) begin
                entries_q[i_wb_tag].done <= 1'b1;
                entries_q[i_wb_tag].data <= i_wb_data;
            end
            if (i_alloc) begin
                entries_q[i_alloc_tag].rdest <= i_alloc_rdest;
                entries_q[i_alloc_tag].done  <= 1'b0;
            end
        end
    end

endmodule

// File: rob_pointers.sv
// Reorder buffer head, tail and occupancy counters with full and empty flags

`timescale 1ns/100ps

`include "rename_config.svh"

module rob_pointers (
    input  logic                   clk,
    input  logic                   n_rst,

    // Allocation at the tail, release at the head, clear on flush
    input  logic                   i_push,
    input  logic                   i_pop,
    input  logic                   i_clear,

    output logic [`TAG_WIDTH-1:0]  o_head,
    output logic [`TAG_WIDTH-1:0]  o_tail,
    output logic [`TAG_WIDTH:0]    o_count,
    output logic                   o_full,
    output logic                   o_empty
);

    logic [`TAG_WIDTH-1:0] head_q;
    logic [`TAG_WIDTH-1:0] tail_q;
    logic [`TAG_WIDTH:0]   count_q;

    // Advance a pointer and wrap after the last entry
    function automatic logic [`TAG_WIDTH-1:0] next_ptr(input logic [`TAG_WIDTH-1:0] ptr);
        if (ptr == `TAG_WIDTH'(`ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + `TAG_WIDTH'(1);
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (i_clear) begin
            // Clear wins over any push or pop in the same cycle
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (i_push) begin
                tail_q <= next_ptr(tail_q);
            end
            if (i_pop) begin
                head_q <= next_ptr(head_q);
            end
            // Count is unchanged when one entry enters and one leaves
            case ({i_push, i_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign o_head  = head_q;
    assign o_tail  = tail_q;
    assign o_count = count_q;
    assign o_full  = (count_q == (`TAG_WIDTH+1)'(`ROB_DEPTH));
    assign o_empty = (count_q == '0);

endmodule

// File: register_map.sv
// Register map: per-register data, producer tag and ready bit with rename, retire and lookup

`timescale 1ns/100ps

`include "rename_config.svh"

module register_map (
    input  logic                            clk,
    input  logic                            n_rst,

    // Flush level, sets every ready bit at the closing edge
    input  logic                            i_flush,

    // Retire write from the head of the reorder buffer
    input  logic [`DATA_WIDTH-1:0]          i_regmap_retire_data,
    input  logic [$clog2(`ADDR_WIDTH)-1:0]  i_regmap_retire_rdest,
    input  logic [`TAG_WIDTH-1:0]           i_regmap_retire_tag,
    input  logic                            i_regmap_retire_wr_en,

    // Rename write for the destination of a newly dispatched instruction
    input  logic [`TAG_WIDTH-1:0]           i_regmap_rename_tag,
    input  logic [$clog2(`ADDR_WIDTH)-1:0]  i_regmap_rename_rdest,
    input  logic                            i_regmap_rename_wr_en,

    // Two source operand lookups
    input  logic [$clog2(`ADDR_WIDTH)-1:0]  i_regmap_lookup_rsrc [0:1],
    output logic                            o_regmap_lookup_rdy  [0:1],
    output logic [`TAG_WIDTH-1:0]           o_regmap_lookup_tag  [0:1],
    output logic [`DATA_WIDTH-1:0]          o_regmap_lookup_data [0:1]
);

    // Architectural value, latest producer tag and ready bit of each register
    logic [`DATA_WIDTH-1:0] data_q [`ADDR_WIDTH];
    logic [`TAG_WIDTH-1:0]  tag_q  [`ADDR_WIDTH];
    logic [`ADDR_WIDTH-1:0] rdy_q;

    logic                   retire_en;
    logic                   rename_en;
    logic [`ADDR_WIDTH-1:0] retire_sel;
    logic [`ADDR_WIDTH-1:0] rename_sel;

    // A write to r0 means the result is thrown away
    assign retire_en  = i_regmap_retire_wr_en && (i_regmap_retire_rdest != '0);
    assign rename_en  = i_regmap_rename_wr_en && (i_regmap_rename_rdest != '0);

    // One-hot select of the register being written by each port
    assign retire_sel = `ADDR_WIDTH'(1) << i_regmap_retire_rdest;
    assign rename_sel = `ADDR_WIDTH'(1) << i_regmap_rename_rdest;

    // Lookups see the state before this cycle's rename
    // so a source equal to the destination finds the older producer
    for (genvar s = 0; s < 2; s++) begin : g_lookup
        assign o_regmap_lookup_rdy[s]  = rdy_q[i_regmap_lookup_rsrc[s]];
        assign o_regmap_lookup_tag[s]  = tag_q[i_regmap_lookup_rsrc[s]];
        assign o_regmap_lookup_data[s] = data_q[i_regmap_lookup_rsrc[s]];
    end

    // The tag records which reorder buffer entry will produce the next value
    always_ff @(posedge clk) begin
        tag_q[0] <= '0;
        for (int i = 1; i < `ADDR_WIDTH; i++) begin
            if (rename_en && rename_sel[i]) begin
                tag_q[i] <= i_regmap_rename_tag;
            end
        end
    end

    // Retired results land here in program order
    // r0 is rewritten with zero every cycle so it reads zero once out of reset
    always_ff @(posedge clk) begin
        data_q[0] <= '0;
        for (int i = 1; i < `ADDR_WIDTH; i++) begin
            if (retire_en && retire_sel[i]) begin
                data_q[i] <= i_regmap_retire_data;
            end
        end
    end

    // Ready bits, bit 0 is never cleared because writes to r0 are dropped
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '1;
        end else if (i_flush) begin
            // Flushed tags will never produce data and the map already holds the last
            // retired value of every register, so all registers become ready again
            rdy_q <= '1;
        end else begin
            for (int i = 1; i < `ADDR_WIDTH; i++) begin
                if (rename_en && rename_sel[i]) begin
                    // A new producer wins over a retirement to the same register
                    rdy_q[i] <= 1'b0;
                end else if (retire_en && retire_sel[i]) begin
                    // Only the latest producer of a register may mark it ready
                    // An older retirement leaves it waiting for the newer one
                    rdy_q[i] <= (i_regmap_retire_tag == tag_q[i]);
                end
            end
        end
    end

endmodule

// File: rename_pkg.sv
// Shared types for the rename unit: reorder buffer entry and retire state encoding

`include "rename_config.svh"

package rename_pkg;

    // One reorder buffer slot
    // The done bit goes high once the execution result has been written back
    // The rdest field says which architectural register receives the data on retirement
    typedef struct packed {
        logic [$clog2(`ADDR_WIDTH)-1:0] rdest;
        logic                           done;
        logic [`DATA_WIDTH-1:0]         data;
    } rob_entry_t;

    // Retire controller states
    // RUN is normal operation, FLUSH lasts a single cycle while everything is cleared
    typedef enum logic {
        RUN   = 1'b0,
        FLUSH = 1'b1
    } retire_state_t;

endpackage

// File: rename_config.svh
// Sizing macros for the rename unit: data width, register count, reorder buffer depth, tag width

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Width of one architectural register value
`define DATA_WIDTH 32

// Number of architectural registers, r0 is hardwired to zero
`define ADDR_WIDTH 16

// Number of reorder buffer entries, kept a power of two
`define ROB_DEPTH 8

// A tag indexes one reorder buffer entry, so this is log2 of the depth
`define TAG_WIDTH 3

`endif
